//--- design/decode_pkg.sv
package decode_pkg;

  parameter int lanes_default = 2;
  parameter int xlen = 32;

  // ~~~~~~~~~~~~~~~~~~~~
  // instruction word views

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // r4 form used by fused multiply-add, funct7 split into rs3 and fmt
  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r4_view_t;

  typedef union packed {
    r_view_t  r_view;
    r4_view_t r4_view;
  } instr_word_u;

  // ~~~~~~~~~~~~~~~~~~~~
  // encodings

  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load_fp  = 7'b0000111,
    opc_store_fp = 7'b0100111,
    opc_op_fp    = 7'b1010011,
    opc_madd     = 7'b1000011
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_mul, alu_mulh, alu_mulhsu, alu_mulhu, alu_div,
    alu_divu, alu_rem, alu_remu, alu_pass
  } alu_op_e;

  typedef enum logic [2:0] {
    fpu_none, fpu_fadd, fpu_fsub, fpu_fmul, fpu_fmadd, fpu_fmv_x_w, fpu_fmv_w_x
  } fpu_op_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // decoded results

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fwren; // fp register file write
    logic frden1;
    logic frden2;
    logic frden3;
    logic fload;
    logic fstore;
    logic fpu;
  } op_flags_t;

  typedef struct packed {
    logic            recognised;
    logic [xlen-1:0] imm;
    op_flags_t       flags;
    alu_op_e         alu_op;
  } int_dec_t;

  typedef struct packed {
    logic            recognised;
    logic [xlen-1:0] imm;
    op_flags_t       flags;
    fpu_op_e         fpu_op;
    logic [2:0]      rm;
    logic [1:0]      fmt;
  } fp_dec_t;

  typedef struct packed {
    logic            valid;
    logic            exception;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] instr;
    logic [4:0]      waddr;
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic [4:0]      raddr3;
    logic [xlen-1:0] imm;
    op_flags_t       flags;
    alu_op_e         alu_op;
    fpu_op_e         fpu_op;
    logic [2:0]      rm;
    logic [1:0]      fmt;
  } lane_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } pred_t;

  typedef struct packed {
    logic            present;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    instr_word_u     word;
  } raw_lane_t;

  localparam lane_t lane_init = '0;
  localparam pred_t pred_init = '0;

endpackage

//--- design/fetch_split.sv
module fetch_split
  import decode_pkg::*;
#(
  parameter int num_lanes = lanes_default
) (
  input  logic                            fetch_ready,
  input  logic [xlen-1:0]                 fetch_pc,
  input  logic [num_lanes-1:0][xlen-1:0]  fetch_data,
  output raw_lane_t [num_lanes-1:0]       split
);

  // one slot per word, word i sits at packet pc + 4*i
  always_comb begin
    logic [xlen-1:0] lane_pc;
    lane_pc = '0;
    for (int i = 0; i < num_lanes; i++) begin
      lane_pc = fetch_pc + (xlen'(i) << 2);
      split[i].present = fetch_ready;
      split[i].pc = lane_pc;
      split[i].npc = lane_pc + xlen'(4);
      // a dead packet feeds zeros so the decoders settle on a known word
      split[i].word = fetch_ready ? fetch_data[i] : '0;
    end
  end

endmodule

//--- design/int_decoder.sv
module int_decoder
  import decode_pkg::*;
(
  input  instr_word_u word,
  output int_dec_t    result
);

  logic [xlen-1:0] bits;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [6:0]      f7;
  logic [2:0]      f3;

  assign bits = word;
  assign f7 = word.r_view.funct7;
  assign f3 = word.r_view.funct3;

  // ~~~~~~~~~~~~~~~~~~~~
  // immediate formats
  assign imm_i = {{20{bits[31]}}, bits[31:20]};
  assign imm_s = {{20{bits[31]}}, bits[31:25], bits[11:7]};
  assign imm_b = {{19{bits[31]}}, bits[31], bits[7], bits[30:25], bits[11:8], 1'b0};
  assign imm_u = {bits[31:12], 12'b0};
  assign imm_j = {{11{bits[31]}}, bits[31], bits[19:12], bits[20], bits[30:21], 1'b0};

  always_comb begin
    result = '0;
    result.alu_op = alu_add;
    case (word.r_view.opcode)
      opc_lui: begin
        result.recognised = 1'b1;
        result.imm = imm_u;
        result.flags.wren = 1'b1;
        result.flags.lui = 1'b1;
        result.alu_op = alu_pass;
      end
      opc_auipc: begin
        result.recognised = 1'b1;
        result.imm = imm_u;
        result.flags.wren = 1'b1;
        result.flags.auipc = 1'b1;
      end
      opc_jal: begin
        result.recognised = 1'b1;
        result.imm = imm_j;
        result.flags.wren = 1'b1; // rd of x0 still flagged, the regfile drops it
        result.flags.jal = 1'b1;
      end
      opc_jalr: begin
        result.recognised = (f3 == 3'b000);
        result.imm = imm_i;
        result.flags.wren = 1'b1;
        result.flags.rden1 = 1'b1;
        result.flags.jalr = 1'b1;
      end
      opc_branch: begin
        result.recognised = (f3 != 3'b010) && (f3 != 3'b011);
        result.imm = imm_b;
        result.flags.rden1 = 1'b1;
        result.flags.rden2 = 1'b1;
        result.flags.branch = 1'b1;
        // beq/bne compare by subtraction, the rest by set-less-than
        if (f3[2:1] == 2'b11) begin
          result.alu_op = alu_sltu;
        end else if (f3[2]) begin
          result.alu_op = alu_slt;
        end else begin
          result.alu_op = alu_sub;
        end
      end
      opc_load: begin
        result.recognised = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
        result.imm = imm_i;
        result.flags.wren = 1'b1;
        result.flags.rden1 = 1'b1;
        result.flags.load = 1'b1;
      end
      opc_store: begin
        result.recognised = (f3[2] == 1'b0) && (f3 != 3'b011);
        result.imm = imm_s;
        result.flags.rden1 = 1'b1;
        result.flags.rden2 = 1'b1;
        result.flags.store = 1'b1;
      end
      opc_op_imm: begin
        result.recognised = 1'b1;
        result.imm = imm_i;
        result.flags.wren = 1'b1;
        result.flags.rden1 = 1'b1;
        result.flags.alu = 1'b1;
        case (f3)
          3'b000: result.alu_op = alu_add;
          3'b010: result.alu_op = alu_slt;
          3'b011: result.alu_op = alu_sltu;
          3'b100: result.alu_op = alu_xor;
          3'b110: result.alu_op = alu_or;
          3'b111: result.alu_op = alu_and;
          3'b001: begin
            result.alu_op = alu_sll;
            result.recognised = (f7 == 7'b0000000);
          end
          default: begin // shift right, funct7 picks arithmetic or logical
            result.alu_op = f7[5] ? alu_sra : alu_srl;
            result.recognised = (f7 == 7'b0000000) || (f7 == 7'b0100000);
          end
        endcase
      end
      opc_op: begin
        result.recognised = 1'b1;
        result.flags.wren = 1'b1;
        result.flags.rden1 = 1'b1;
        result.flags.rden2 = 1'b1;
        result.flags.alu = 1'b1;
        case (f7)
          7'b0000000: begin
            case (f3)
              3'b000: result.alu_op = alu_add;
              3'b001: result.alu_op = alu_sll;
              3'b010: result.alu_op = alu_slt;
              3'b011: result.alu_op = alu_sltu;
              3'b100: result.alu_op = alu_xor;
              3'b101: result.alu_op = alu_srl;
              3'b110: result.alu_op = alu_or;
              default: result.alu_op = alu_and;
            endcase
          end
          7'b0100000: begin
            result.alu_op = (f3 == 3'b101) ? alu_sra : alu_sub;
            result.recognised = (f3 == 3'b000) || (f3 == 3'b101);
          end
          7'b0000001: begin
            case (f3) // M extension
              3'b000: result.alu_op = alu_mul;
              3'b001: result.alu_op = alu_mulh;
              3'b010: result.alu_op = alu_mulhsu;
              3'b011: result.alu_op = alu_mulhu;
              3'b100: result.alu_op = alu_div;
              3'b101: result.alu_op = alu_divu;
              3'b110: result.alu_op = alu_rem;
              default: result.alu_op = alu_remu;
            endcase
          end
          default: result.recognised = 1'b0;
        endcase
      end
      default: result.recognised = 1'b0;
    endcase
  end

endmodule

//--- design/fp_decoder.sv
module fp_decoder
  import decode_pkg::*;
(
  input  instr_word_u word,
  output fp_dec_t     result
);

  logic [xlen-1:0] bits;
  logic            rm_reserved;
  logic            single_fmt;
  logic            move_form;

  assign bits = word;
  assign rm_reserved = (word.r4_view.rm == 3'd5) || (word.r4_view.rm == 3'd6);
  assign single_fmt = (word.r4_view.fmt == 2'b00);
  // moves have no rs2 and a fixed zero rm
  assign move_form = (word.r4_view.rs2 == 5'd0) && (word.r4_view.rm == 3'b000);

  always_comb begin
    result = '0;
    result.rm = word.r4_view.rm;
    result.fmt = word.r4_view.fmt;
    case (word.r4_view.opcode)
      opc_load_fp: begin
        result.recognised = (word.r4_view.rm == 3'b010); // width field, word only
        result.imm = {{20{bits[31]}}, bits[31:20]};
        result.flags.rden1 = 1'b1;
        result.flags.fwren = 1'b1;
        result.flags.fload = 1'b1;
      end
      opc_store_fp: begin
        result.recognised = (word.r4_view.rm == 3'b010);
        result.imm = {{20{bits[31]}}, bits[31:25], bits[11:7]};
        result.flags.rden1 = 1'b1;
        result.flags.frden2 = 1'b1;
        result.flags.fstore = 1'b1;
      end
      opc_op_fp: begin
        result.flags.fpu = 1'b1;
        case (word.r4_view.rs3) // funct5
          5'b00000, 5'b00001, 5'b00010: begin
            result.recognised = single_fmt && !rm_reserved;
            result.flags.fwren = 1'b1;
            result.flags.frden1 = 1'b1;
            result.flags.frden2 = 1'b1;
            if (word.r4_view.rs3[1]) begin
              result.fpu_op = fpu_fmul;
            end else begin
              result.fpu_op = word.r4_view.rs3[0] ? fpu_fsub : fpu_fadd;
            end
          end
          5'b11100: begin
            result.recognised = single_fmt && move_form;
            result.flags.wren = 1'b1;
            result.flags.frden1 = 1'b1;
            result.fpu_op = fpu_fmv_x_w;
          end
          5'b11110: begin
            result.recognised = single_fmt && move_form;
            result.flags.rden1 = 1'b1;
            result.flags.fwren = 1'b1;
            result.fpu_op = fpu_fmv_w_x;
          end
          default: result.recognised = 1'b0;
        endcase
      end
      opc_madd: begin
        result.recognised = single_fmt && !rm_reserved;
        result.flags.fwren = 1'b1;
        result.flags.frden1 = 1'b1;
        result.flags.frden2 = 1'b1;
        result.flags.frden3 = 1'b1;
        result.flags.fpu = 1'b1;
        result.fpu_op = fpu_fmadd;
      end
      default: result.recognised = 1'b0;
    endcase
  end

endmodule

//--- design/decode_lane.sv
module decode_lane
  import decode_pkg::*;
(
  input  raw_lane_t raw,
  output lane_t     lane
);

  int_dec_t int_res;
  fp_dec_t  fp_res;

  int_decoder u_int_decoder (
    .word   (raw.word),
    .result (int_res)
  );

  fp_decoder u_fp_decoder (
    .word   (raw.word),
    .result (fp_res)
  );

  always_comb begin
    lane = lane_init;
    if (raw.present) begin
      lane.valid = 1'b1;
      lane.pc = raw.pc;
      lane.npc = raw.npc;
      lane.instr = raw.word;
      lane.waddr = raw.word.r_view.rd;
      lane.raddr1 = raw.word.r_view.rs1;
      lane.raddr2 = raw.word.r_view.rs2;
      lane.raddr3 = raw.word.r4_view.rs3;
      if (fp_res.recognised) begin // fp wins on overlap
        lane.imm = fp_res.imm;
        lane.flags = fp_res.flags;
        lane.fpu_op = fp_res.fpu_op;
        lane.rm = fp_res.rm;
        lane.fmt = fp_res.fmt;
        lane.alu_op = alu_pass;
      end else if (int_res.recognised) begin
        lane.imm = int_res.imm;
        lane.flags = int_res.flags;
        lane.alu_op = int_res.alu_op;
      end else begin
        lane.exception = 1'b1; // illegal word, flags stay clear
      end
    end
  end

endmodule

//--- design/decode_register.sv
module decode_register
  import decode_pkg::*;
#(
  parameter int num_lanes = lanes_default
) (
  input  logic                   clock,
  input  logic                   reset,
  input  lane_t [num_lanes-1:0]  lanes_in,
  input  pred_t                  fetch_pred,
  input  logic                   halt,
  input  logic                   flush,
  output lane_t [num_lanes-1:0]  lanes,
  output pred_t                  pred
);

  lane_t [num_lanes-1:0] lanes_next;
  pred_t                 pred_next;
  logic                  drop;

  // ~~~~~~~~~~~~~~~~~~~~
  // next state

  // the issue side refetches a halted packet, so it is dropped like a flushed one
  assign drop = flush || halt;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lanes_next[i] = drop ? lane_init : lanes_in[i];
    end
  end

  // keep the prediction that belongs to the packet fetch will present again
  assign pred_next = halt ? pred : fetch_pred;

  // ~~~~~~~~~~~~~~~~~~~~
  // output register

  always_ff @(posedge clock) begin
    if (!reset) begin
      lanes <= '0;
      pred <= pred_init;
    end else begin
      lanes <= lanes_next;
      pred <= pred_next;
    end
  end

endmodule

//--- design/decode_stage.sv
module decode_stage
  import decode_pkg::*;
#(
  parameter int num_lanes = lanes_default
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           fetch_ready,
  input  logic [xlen-1:0]                fetch_pc,
  input  logic [num_lanes-1:0][xlen-1:0] fetch_data,
  input  pred_t                          fetch_pred,
  input  logic                           halt,
  input  logic                           flush,
  output lane_t [num_lanes-1:0]          lanes,
  output pred_t                          pred
);

  raw_lane_t [num_lanes-1:0] split;
  lane_t     [num_lanes-1:0] decoded;

  fetch_split #(.num_lanes(num_lanes)) u_fetch_split (
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .split       (split)
  );

  for (genvar g = 0; g < num_lanes; g++) begin : g_lane
    decode_lane u_decode_lane (
      .raw  (split[g]),
      .lane (decoded[g])
    );
  end

  decode_register #(.num_lanes(num_lanes)) u_decode_register (
    .clock      (clock),
    .reset      (reset),
    .lanes_in   (decoded),
    .fetch_pred (fetch_pred),
    .halt       (halt),
    .flush      (flush),
    .lanes      (lanes),
    .pred       (pred)
  );

endmodule

//--- dv/decode_chk.sv
module decode_chk
  import decode_pkg::*;
#(
  parameter int num_lanes = lanes_default
) (
  input logic                  clock,
  input logic                  reset,
  input lane_t [num_lanes-1:0] lanes,
  input pred_t                 pred,
  input logic                  halt,
  input logic                  flush
);

  logic any_valid;

  always_comb begin
    any_valid = 1'b0;
    for (int i = 0; i < num_lanes; i++) begin
      any_valid = any_valid | lanes[i].valid;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // register stage rules

  flush_empties: assert property (@(posedge clock) disable iff (!reset) flush |=> !any_valid)
    else $error("a lane is still valid in the cycle after a flush");

  // a halted packet is presented again, so its prediction must not move
  halt_holds_pred: assert property (@(posedge clock) disable iff (!reset) halt |=> $stable(pred))
    else $error("the prediction changed across a halt cycle");

  for (genvar g = 0; g < num_lanes; g++) begin : g_lane
    exception_is_valid: assert property (@(posedge clock) lanes[g].exception |-> lanes[g].valid)
      else $error("lane %0d has an exception without valid", g);
    one_unit: assert property (@(posedge clock) !(lanes[g].flags.fpu && lanes[g].flags.alu))
      else $error("lane %0d targets both the fpu and the alu", g);
  end

endmodule

//--- dv/decode_tb.sv
module decode_tb
  import decode_pkg::*;
();

  localparam int n_cases = 16;
  localparam int n_packets = 15;
  localparam int n_random = 40;
  localparam int period = 4;

  // one instruction word with its hand-decoded result
  typedef struct packed {
    logic [31:0] word;
    logic        exc;
    logic [31:0] imm;
    alu_op_e     alu_op;
    fpu_op_e     fpu_op;
    op_flags_t   flags;
    logic        fp; // rm and fmt are carried only for fp words
  } word_case_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [3:0]  w0;
    logic [3:0]  w1;
    logic        ready;
    logic        halt;
    logic        flush;
    pred_t       pred;
  } packet_t;

  // flag bits from wren down to fpu, in op_flags_t order
  localparam word_case_t cases [n_cases] = '{
    '{32'hFFD30293, 1'b0, 32'hFFFFFFFD, alu_add, fpu_none, 18'b110100000000000000, 1'b0},
    '{32'h123453B7, 1'b0, 32'h12345000, alu_pass, fpu_none, 18'b100010000000000000, 1'b0},
    '{32'h001000EF, 1'b0, 32'h00000800, alu_add, fpu_none, 18'b100000100000000000, 1'b0},
    '{32'hFE310CE3, 1'b0, 32'hFFFFFFF8, alu_sub, fpu_none, 18'b011000001000000000, 1'b0},
    '{32'h00442623, 1'b0, 32'h0000000C, alu_add, fpu_none, 18'b011000000010000000, 1'b0},
    '{32'h02C58533, 1'b0, 32'h00000000, alu_mul, fpu_none, 18'b111100000000000000, 1'b0},
    '{32'h02F756B3, 1'b0, 32'h00000000, alu_divu, fpu_none, 18'b111100000000000000, 1'b0},
    '{32'h01012087, 1'b0, 32'h00000010, alu_pass, fpu_none, 18'b010000000001000100, 1'b1},
    '{32'h0032AA27, 1'b0, 32'h00000014, alu_pass, fpu_none, 18'b010000000000010010, 1'b1},
    '{32'h0062F253, 1'b0, 32'h00000000, alu_pass, fpu_fadd, 18'b000000000001110001, 1'b1},
    '{32'h509403C3, 1'b0, 32'h00000000, alu_pass, fpu_fmadd, 18'b000000000001111001, 1'b1},
    '{32'hE00605D3, 1'b0, 32'h00000000, alu_pass, fpu_fmv_x_w, 18'b100000000000100001, 1'b1},
    '{32'h00000000, 1'b1, 32'h00000000, alu_add, fpu_none, 18'b0, 1'b0}, // all zero
    '{32'h0000007F, 1'b1, 32'h00000000, alu_add, fpu_none, 18'b0, 1'b0}, // unknown opcode
    '{32'h0262F253, 1'b1, 32'h00000000, alu_add, fpu_none, 18'b0, 1'b0}, // fadd.d
    '{32'h0062D253, 1'b1, 32'h00000000, alu_add, fpu_none, 18'b0, 1'b0}  // reserved rm
  };

  localparam packet_t packets [n_packets] = '{
    '{32'h0000_0100, 4'd0, 4'd1, 1'b0, 1'b0, 1'b0, '{1'b0, 32'h0000_0000}},
    '{32'h0000_1000, 4'd0, 4'd1, 1'b1, 1'b0, 1'b0, '{1'b1, 32'h0000_2000}},
    '{32'h0000_1008, 4'd2, 4'd3, 1'b1, 1'b0, 1'b0, '{1'b0, 32'h0000_1010}},
    '{32'h0000_1010, 4'd4, 4'd5, 1'b1, 1'b0, 1'b0, '{1'b1, 32'h0000_0400}},
    '{32'h0000_1018, 4'd6, 4'd7, 1'b1, 1'b0, 1'b0, '{1'b0, 32'h0000_1020}},
    '{32'h0000_1020, 4'd8, 4'd9, 1'b1, 1'b0, 1'b0, '{1'b0, 32'h0000_1028}},
    '{32'h0000_1028, 4'd10, 4'd11, 1'b1, 1'b0, 1'b0, '{1'b1, 32'h0000_0800}},
    '{32'h0000_1030, 4'd12, 4'd13, 1'b1, 1'b0, 1'b0, '{1'b0, 32'h0000_1038}},
    '{32'h0000_1038, 4'd14, 4'd15, 1'b1, 1'b0, 1'b0, '{1'b0, 32'h0000_1040}},
    '{32'h0000_1040, 4'd5, 4'd9, 1'b0, 1'b0, 1'b0, '{1'b1, 32'h0000_2222}},
    '{32'h0000_1040, 4'd5, 4'd9, 1'b1, 1'b1, 1'b0, '{1'b0, 32'h0000_3333}},
    '{32'h0000_1040, 4'd5, 4'd9, 1'b1, 1'b1, 1'b0, '{1'b1, 32'h0000_4444}},
    '{32'h0000_1040, 4'd5, 4'd9, 1'b1, 1'b0, 1'b0, '{1'b1, 32'h0000_5555}},
    '{32'h0000_1048, 4'd0, 4'd10, 1'b1, 1'b0, 1'b1, '{1'b0, 32'h0000_6666}},
    '{32'h0000_1050, 4'd11, 4'd6, 1'b1, 1'b0, 1'b0, '{1'b1, 32'h0000_7777}}
  };

  logic                clock;
  logic                reset;
  logic                fetch_ready;
  logic [31:0]         fetch_pc;
  logic [1:0][31:0]    fetch_data;
  pred_t               fetch_pred;
  logic                halt;
  logic                flush;
  lane_t [1:0]         lanes;
  pred_t               pred;

  int          errors;
  logic [31:0] rng;
  lane_t [1:0] exp_lanes; // what the outputs hold after the packet driven last
  pred_t       exp_pred;
  packet_t     rand_pkt;

  decode_stage #(.num_lanes(2)) dut (
    .clock       (clock),
    .reset       (reset),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .fetch_pred  (fetch_pred),
    .halt        (halt),
    .flush       (flush),
    .lanes       (lanes),
    .pred        (pred)
  );

  bind decode_register decode_chk #(.num_lanes(num_lanes)) u_decode_chk (
    .clock (clock),
    .reset (reset),
    .lanes (lanes),
    .pred  (pred),
    .halt  (halt),
    .flush (flush)
  );

  always #(period / 2) clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // register fields sit at fixed bit positions in every format
  function automatic lane_t expect_lane(input word_case_t wc, input logic [31:0] pc);
    lane_t l;
    l = '0;
    l.valid = 1'b1;
    l.exception = wc.exc;
    l.pc = pc;
    l.npc = pc + 32'd4;
    l.instr = wc.word;
    l.waddr = wc.word[11:7];
    l.raddr1 = wc.word[19:15];
    l.raddr2 = wc.word[24:20];
    l.raddr3 = wc.word[31:27];
    l.imm = wc.imm;
    l.flags = wc.flags;
    l.alu_op = wc.alu_op;
    l.fpu_op = wc.fpu_op;
    if (wc.fp) begin
      l.rm = wc.word[14:12];
      l.fmt = wc.word[26:25];
    end
    return l;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] e, input logic [31:0] a);
    if (a !== e) begin
      errors++;
      $display("Fail %s expected %h actual %h at %0t", name, e, a, $time);
    end
  endtask

  task automatic check_lane(input int idx, input lane_t e, input lane_t a);
    string n;
    n = $sformatf("lanes[%0d]", idx);
    compare_field({n, ".valid"}, 32'(e.valid), 32'(a.valid));
    compare_field({n, ".exception"}, 32'(e.exception), 32'(a.exception));
    compare_field({n, ".pc"}, e.pc, a.pc);
    compare_field({n, ".npc"}, e.npc, a.npc);
    compare_field({n, ".instr"}, e.instr, a.instr);
    compare_field({n, ".waddr"}, 32'(e.waddr), 32'(a.waddr));
    compare_field({n, ".raddr1"}, 32'(e.raddr1), 32'(a.raddr1));
    compare_field({n, ".raddr2"}, 32'(e.raddr2), 32'(a.raddr2));
    compare_field({n, ".raddr3"}, 32'(e.raddr3), 32'(a.raddr3));
    compare_field({n, ".imm"}, e.imm, a.imm);
    compare_field({n, ".flags"}, 32'(e.flags), 32'(a.flags));
    compare_field({n, ".alu_op"}, 32'(e.alu_op), 32'(a.alu_op));
    compare_field({n, ".fpu_op"}, 32'(e.fpu_op), 32'(a.fpu_op));
    compare_field({n, ".rm"}, 32'(e.rm), 32'(a.rm));
    compare_field({n, ".fmt"}, 32'(e.fmt), 32'(a.fmt));
  endtask

  task automatic check_pred(input pred_t e, input pred_t a);
    compare_field("pred.taken", 32'(e.taken), 32'(a.taken));
    compare_field("pred.target", e.target, a.target);
  endtask

  // drives one packet, checks the one before it, then predicts this one
  task automatic run_packet(input packet_t p);
    @(posedge clock);
    fetch_ready <= p.ready;
    fetch_pc <= p.pc;
    fetch_data <= {cases[p.w1].word, cases[p.w0].word};
    fetch_pred <= p.pred;
    halt <= p.halt;
    flush <= p.flush;
    @(negedge clock);
    check_lane(0, exp_lanes[0], lanes[0]);
    check_lane(1, exp_lanes[1], lanes[1]);
    check_pred(exp_pred, pred);
    if (!p.ready || p.halt || p.flush) begin
      exp_lanes = '0;
    end else begin
      exp_lanes[0] = expect_lane(cases[p.w0], p.pc);
      exp_lanes[1] = expect_lane(cases[p.w1], p.pc + 32'd4);
    end
    exp_pred = p.halt ? exp_pred : p.pred;
  endtask

  initial begin
    #((n_packets + n_random + 20) * period);
    $display("timeout, the test sequence never reached its end");
    $display("tests failed");
    $finish;
  end

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    fetch_ready = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    fetch_pred = '0;
    halt = 1'b0;
    flush = 1'b0;
    errors = 0;
    rng = 32'h9158_7b2e;
    exp_lanes = '0;
    exp_pred = '0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_lane(0, '0, lanes[0]); // outputs under reset
    check_lane(1, '0, lanes[1]);
    check_pred('0, pred);
    @(posedge clock);
    reset <= 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~
    // directed table
    for (int i = 0; i < n_packets; i++) begin
      run_packet(packets[i]);
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // random packets built from known words
    for (int i = 0; i < n_random; i++) begin
      rng = xorshift(rng);
      rand_pkt.pc = {rng[31:2], 2'b00};
      rng = xorshift(rng);
      rand_pkt.pred.taken = rng[0];
      rand_pkt.pred.target = rng;
      rng = xorshift(rng);
      rand_pkt.w0 = rng[3:0];
      rand_pkt.w1 = rng[7:4];
      rand_pkt.ready = (rng[10:8] != 3'd0);
      rand_pkt.halt = (rng[12:11] == 2'd0);
      rand_pkt.flush = (rng[14:13] == 2'd0);
      run_packet(rand_pkt);
    end
    run_packet(packets[0]); // idle packet so the last random one is checked

    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
design/decode_pkg.sv
design/fetch_split.sv
design/int_decoder.sv
design/fp_decoder.sv
design/decode_lane.sv
design/decode_register.sv
design/decode_stage.sv
dv/decode_chk.sv
dv/decode_tb.sv

//--- Makefile
.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
obj_dir/decode_sim: build.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --assert --top-module decode_tb -f build.f -o decode_sim

# the pipeline status is the status of grep, so a missing pass line fails the target
run: obj_dir/decode_sim
	obj_dir/decode_sim | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
